// ==== rtl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// ************************************************************************
	// Widths and memory sizes
	// ************************************************************************

	localparam int DATA_W     = 16;
	localparam int REG_ADDR_W = 4;
	localparam int BYTE_W     = 8;
	localparam int IMEM_DEPTH = 256;
	localparam int DMEM_DEPTH = 256;

	// ************************************************************************
	// Instruction set encodings
	// ************************************************************************

	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_XOR = 4'd2,
		OP_AND = 4'd3,
		OP_SLL = 4'd4,
		OP_SRA = 4'd5,
		OP_ROR = 4'd6,
		OP_OR  = 4'd7,
		OP_LW  = 4'd8,
		OP_SW  = 4'd9,
		OP_LHB = 4'd10,
		OP_LLB = 4'd11,
		OP_B   = 4'd12,
		OP_BR  = 4'd13,
		OP_PCS = 4'd14,
		OP_HLT = 4'd15
	} opcode_e;

	// Branch conditions, bits 11..9 of B and BR
	typedef enum logic [2:0] {
		COND_NE = 3'd0,
		COND_EQ = 3'd1,
		COND_GT = 3'd2,
		COND_LT = 3'd3,
		COND_GE = 3'd4,
		COND_LE = 3'd5,
		COND_OV = 3'd6,
		COND_UN = 3'd7
	} cond_e;

	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flags_t;

	// Register write-back source
	typedef enum logic [1:0] {
		WB_ALU  = 2'd0,
		WB_MEM  = 2'd1,
		WB_PC   = 2'd2,
		WB_BYTE = 2'd3
	} wb_sel_e;

endpackage

`default_nettype wire

// ==== rtl/decode_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface decode_if;

	cpu_pkg::opcode_e                 opcode;
	logic [cpu_pkg::REG_ADDR_W-1:0]   rd_addr;
	logic [cpu_pkg::REG_ADDR_W-1:0]   rs_addr;
	logic [cpu_pkg::REG_ADDR_W-1:0]   rt_addr;
	logic [cpu_pkg::DATA_W-1:0]       imm_ext;
	logic [cpu_pkg::BYTE_W-1:0]       byte_val;
	cpu_pkg::cond_e                   cond;
	logic [cpu_pkg::DATA_W-1:0]       off9_ext;

	// Control
	logic                             reg_we;
	logic                             use_imm;
	logic                             mem_re;
	logic                             mem_we;
	logic                             flag_we;
	cpu_pkg::wb_sel_e                 wb_sel;
	logic                             halt;

	modport dec (
		output opcode, rd_addr, rs_addr, rt_addr,
		output imm_ext, byte_val, cond, off9_ext,
		output reg_we, use_imm, mem_re, mem_we, flag_we, wb_sel, halt
	);

	modport dp (
		input opcode, rd_addr, rs_addr, rt_addr,
		input imm_ext, byte_val, cond, off9_ext,
		input reg_we, use_imm, mem_re, mem_we, flag_we, wb_sel, halt
	);

endinterface

`default_nettype wire

// ==== rtl/decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module decoder (
	input  logic [cpu_pkg::DATA_W-1:0] instr_i,
	decode_if.dec                      ctrl_o
);

	cpu_pkg::opcode_e               op;
	logic [cpu_pkg::REG_ADDR_W-1:0] rd_field;

	assign op       = cpu_pkg::opcode_e'(instr_i[15:12]);
	assign rd_field = instr_i[11:8];

	always_comb begin
		ctrl_o.opcode   = op;
		ctrl_o.rd_addr  = rd_field;
		ctrl_o.rs_addr  = instr_i[7:4];
		ctrl_o.rt_addr  = instr_i[3:0];
		ctrl_o.imm_ext  = {{(cpu_pkg::DATA_W-4){instr_i[3]}}, instr_i[3:0]};
		ctrl_o.byte_val = instr_i[7:0];
		ctrl_o.cond     = cpu_pkg::cond_e'(instr_i[11:9]);
		ctrl_o.off9_ext = {{(cpu_pkg::DATA_W-9){instr_i[8]}}, instr_i[8:0]};

		ctrl_o.reg_we   = 1'b0;
		ctrl_o.use_imm  = 1'b0;
		ctrl_o.mem_re   = 1'b0;
		ctrl_o.mem_we   = 1'b0;
		ctrl_o.flag_we  = 1'b0;
		ctrl_o.wb_sel   = cpu_pkg::WB_ALU;
		ctrl_o.halt     = 1'b0;

		case (op)
			cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_XOR,
			cpu_pkg::OP_AND, cpu_pkg::OP_OR: begin
				ctrl_o.reg_we  = 1'b1;
				ctrl_o.flag_we = 1'b1;
			end
			cpu_pkg::OP_SLL, cpu_pkg::OP_SRA, cpu_pkg::OP_ROR: begin
				ctrl_o.reg_we  = 1'b1;
				ctrl_o.flag_we = 1'b1;
				ctrl_o.use_imm = 1'b1;
			end
			cpu_pkg::OP_LW: begin
				ctrl_o.reg_we = 1'b1;
				ctrl_o.mem_re = 1'b1;
				ctrl_o.wb_sel = cpu_pkg::WB_MEM;
			end
			cpu_pkg::OP_SW: begin
				// Store data comes from the rd field
				ctrl_o.mem_we  = 1'b1;
				ctrl_o.rt_addr = rd_field;
			end
			cpu_pkg::OP_LHB, cpu_pkg::OP_LLB: begin
				ctrl_o.reg_we  = 1'b1;
				ctrl_o.wb_sel  = cpu_pkg::WB_BYTE;
				ctrl_o.rs_addr = rd_field;
			end
			cpu_pkg::OP_PCS: begin
				ctrl_o.reg_we = 1'b1;
				ctrl_o.wb_sel = cpu_pkg::WB_PC;
			end
			cpu_pkg::OP_HLT: begin
				ctrl_o.halt = 1'b1;
			end
			default: begin
			end
		endcase

		// r0 is hardwired
		if (rd_field == '0) begin
			ctrl_o.reg_we = 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/pc_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module pc_control (
	input  logic [cpu_pkg::DATA_W-1:0] pc_i,
	input  logic [cpu_pkg::DATA_W-1:0] rs_val_i,
	input  cpu_pkg::flags_t            flags_i,
	decode_if.dp                       ctrl_i,
	output logic [cpu_pkg::DATA_W-1:0] pc_next_o
);

	logic [cpu_pkg::DATA_W-1:0] pc_plus1;
	logic                       cond_ok;

	assign pc_plus1 = pc_i + 1'b1;

	always_comb begin
		case (ctrl_i.cond)
			cpu_pkg::COND_NE: cond_ok = ~flags_i.z;
			cpu_pkg::COND_EQ: cond_ok = flags_i.z;
			cpu_pkg::COND_GT: cond_ok = ~flags_i.z & ~flags_i.n;
			cpu_pkg::COND_LT: cond_ok = flags_i.n;
			cpu_pkg::COND_GE: cond_ok = ~flags_i.n;
			cpu_pkg::COND_LE: cond_ok = flags_i.z | flags_i.n;
			cpu_pkg::COND_OV: cond_ok = flags_i.v;
			default:          cond_ok = 1'b1;
		endcase
	end

	always_comb begin
		pc_next_o = pc_plus1;
		if (ctrl_i.halt) begin
			pc_next_o = pc_i;
		end else if (cond_ok) begin
			if (ctrl_i.opcode == cpu_pkg::OP_B) begin
				// Relative to the following instruction
				pc_next_o = pc_plus1 + ctrl_i.off9_ext;
			end else if (ctrl_i.opcode == cpu_pkg::OP_BR) begin
				pc_next_o = rs_val_i;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module register_file (
	input  logic                           clk,
	input  logic                           rst_n_i,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr1_i,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr2_i,
	output logic [cpu_pkg::DATA_W-1:0]     rdata1_o,
	output logic [cpu_pkg::DATA_W-1:0]     rdata2_o,
	input  logic                           we_i,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] waddr_i,
	input  logic [cpu_pkg::DATA_W-1:0]     wdata_i
);

	logic [cpu_pkg::DATA_W-1:0] regs [2**cpu_pkg::REG_ADDR_W];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < 2**cpu_pkg::REG_ADDR_W; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// Index 0 always reads zero
	assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  logic [cpu_pkg::DATA_W-1:0] a_i,
	input  logic [cpu_pkg::DATA_W-1:0] b_i,
	decode_if.dp                       ctrl_i,
	output logic [cpu_pkg::DATA_W-1:0] result_o,
	output logic [cpu_pkg::DATA_W-1:0] addr_o,
	output cpu_pkg::flags_t            flags_o
);

	logic [cpu_pkg::DATA_W-1:0]   sum;
	logic [cpu_pkg::DATA_W-1:0]   diff;
	logic [3:0]                   shamt;
	logic [2*cpu_pkg::DATA_W-1:0] rot;
	logic                         ovf_add;
	logic                         ovf_sub;
	cpu_pkg::flags_t              flags_q;

	// ************************************************************************
	// Operations
	// ************************************************************************

	assign sum   = a_i + b_i;
	assign diff  = a_i - b_i;
	assign shamt = b_i[3:0];
	assign rot   = {a_i, a_i} >> shamt;

	assign ovf_add = (a_i[cpu_pkg::DATA_W-1] == b_i[cpu_pkg::DATA_W-1]) &&
	                 (sum[cpu_pkg::DATA_W-1] != a_i[cpu_pkg::DATA_W-1]);
	assign ovf_sub = (a_i[cpu_pkg::DATA_W-1] != b_i[cpu_pkg::DATA_W-1]) &&
	                 (diff[cpu_pkg::DATA_W-1] != a_i[cpu_pkg::DATA_W-1]);

	always_comb begin
		case (ctrl_i.opcode)
			cpu_pkg::OP_ADD: result_o = sum;
			cpu_pkg::OP_SUB: result_o = diff;
			cpu_pkg::OP_XOR: result_o = a_i ^ b_i;
			cpu_pkg::OP_AND: result_o = a_i & b_i;
			cpu_pkg::OP_SLL: result_o = a_i << shamt;
			cpu_pkg::OP_SRA: result_o = $signed(a_i) >>> shamt;
			cpu_pkg::OP_ROR: result_o = rot[cpu_pkg::DATA_W-1:0];
			cpu_pkg::OP_OR:  result_o = a_i | b_i;
			default:         result_o = '0;
		endcase
	end

	// Word address for LW and SW
	assign addr_o = a_i + ctrl_i.imm_ext;

	// ************************************************************************
	// Flag register
	// ************************************************************************

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			flags_q <= '0;
		end else if (ctrl_i.flag_we) begin
			flags_q.z <= (result_o == '0);
			if (ctrl_i.opcode == cpu_pkg::OP_ADD) begin
				flags_q.v <= ovf_add;
				flags_q.n <= sum[cpu_pkg::DATA_W-1];
			end else if (ctrl_i.opcode == cpu_pkg::OP_SUB) begin
				flags_q.v <= ovf_sub;
				flags_q.n <= diff[cpu_pkg::DATA_W-1];
			end
		end
	end

	assign flags_o = flags_q;

endmodule

`default_nettype wire

// ==== rtl/word_memory.sv ====
`timescale 1ns/1ns
`default_nettype none

module word_memory #(
	parameter int DEPTH = 256
) (
	input  logic                       clk,
	input  logic                       we_i,
	input  logic [cpu_pkg::DATA_W-1:0] addr_i,
	input  logic [cpu_pkg::DATA_W-1:0] wdata_i,
	output logic [cpu_pkg::DATA_W-1:0] rdata_o
);

	logic [cpu_pkg::DATA_W-1:0] mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]   idx;

	// Upper address bits are ignored
	assign idx = addr_i[$clog2(DEPTH)-1:0];

	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[idx] <= wdata_i;
		end
	end

	assign rdata_o = mem[idx];

endmodule

`default_nettype wire

// ==== rtl/cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu (
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  logic                       imem_we_i,
	input  logic [7:0]                 imem_addr_i,
	input  logic [cpu_pkg::DATA_W-1:0] imem_wdata_i,
	output logic                       hlt_o,
	output logic [cpu_pkg::DATA_W-1:0] pc_o,
	output logic                       st_valid_o,
	output logic [cpu_pkg::DATA_W-1:0] st_addr_o,
	output logic [cpu_pkg::DATA_W-1:0] st_data_o
);

	logic [cpu_pkg::DATA_W-1:0] pc_q;
	logic [cpu_pkg::DATA_W-1:0] pc_next;
	logic [cpu_pkg::DATA_W-1:0] imem_addr;
	logic [cpu_pkg::DATA_W-1:0] instr;
	logic [cpu_pkg::DATA_W-1:0] rs_val;
	logic [cpu_pkg::DATA_W-1:0] rt_val;
	logic [cpu_pkg::DATA_W-1:0] alu_b;
	logic [cpu_pkg::DATA_W-1:0] alu_result;
	logic [cpu_pkg::DATA_W-1:0] mem_addr;
	logic [cpu_pkg::DATA_W-1:0] dmem_rdata;
	logic [cpu_pkg::DATA_W-1:0] ld_data;
	logic [cpu_pkg::DATA_W-1:0] byte_merge;
	logic [cpu_pkg::DATA_W-1:0] wb_data;
	cpu_pkg::flags_t            flags;

	decode_if ctrl ();

	// ************************************************************************
	// Fetch and PC
	// ************************************************************************

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc_q <= '0;
		end else begin
			pc_q <= pc_next;
		end
	end

	// Load port borrows the fetch address while writing
	assign imem_addr = imem_we_i ? {{(cpu_pkg::DATA_W-8){1'b0}}, imem_addr_i} : pc_q;

	word_memory #(.DEPTH(cpu_pkg::IMEM_DEPTH)) u_imem (
		.clk     (clk),
		.we_i    (imem_we_i),
		.addr_i  (imem_addr),
		.wdata_i (imem_wdata_i),
		.rdata_o (instr)
	);

	decoder u_decoder (
		.instr_i (instr),
		.ctrl_o  (ctrl.dec)
	);

	pc_control u_pc_control (
		.pc_i      (pc_q),
		.rs_val_i  (rs_val),
		.flags_i   (flags),
		.ctrl_i    (ctrl.dp),
		.pc_next_o (pc_next)
	);

	// ************************************************************************
	// Execute and memory
	// ************************************************************************

	register_file u_regfile (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.raddr1_i (ctrl.rs_addr),
		.raddr2_i (ctrl.rt_addr),
		.rdata1_o (rs_val),
		.rdata2_o (rt_val),
		.we_i     (ctrl.reg_we),
		.waddr_i  (ctrl.rd_addr),
		.wdata_i  (wb_data)
	);

	assign alu_b = ctrl.use_imm ? ctrl.imm_ext : rt_val;

	alu u_alu (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.a_i      (rs_val),
		.b_i      (alu_b),
		.ctrl_i   (ctrl.dp),
		.result_o (alu_result),
		.addr_o   (mem_addr),
		.flags_o  (flags)
	);

	word_memory #(.DEPTH(cpu_pkg::DMEM_DEPTH)) u_dmem (
		.clk     (clk),
		.we_i    (st_valid_o),
		.addr_i  (mem_addr),
		.wdata_i (rt_val),
		.rdata_o (dmem_rdata)
	);

	assign ld_data = ctrl.mem_re ? dmem_rdata : '0;

	// ************************************************************************
	// Write-back
	// ************************************************************************

	// rs_val holds the old rd here
	assign byte_merge = (ctrl.opcode == cpu_pkg::OP_LHB) ?
	                    {ctrl.byte_val, rs_val[7:0]} :
	                    {rs_val[15:8], ctrl.byte_val};

	always_comb begin
		case (ctrl.wb_sel)
			cpu_pkg::WB_MEM:  wb_data = ld_data;
			cpu_pkg::WB_PC:   wb_data = pc_next;
			cpu_pkg::WB_BYTE: wb_data = byte_merge;
			default:          wb_data = alu_result;
		endcase
	end

	assign st_valid_o = ctrl.mem_we & rst_n_i;
	assign st_addr_o  = mem_addr;
	assign st_data_o  = rt_val;
	assign hlt_o      = ctrl.halt;
	assign pc_o       = pc_q;

endmodule

`default_nettype wire

// ==== test/cpu_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_checker (
	input logic                       clk,
	input logic                       rst_n_i,
	input logic                       hlt_i,
	input logic                       st_valid_i,
	input logic [cpu_pkg::DATA_W-1:0] pc_i
);

	// PC frozen once halted
	halt_holds_pc: assert property (
		@(posedge clk) disable iff (!rst_n_i) hlt_i |=> $stable(pc_i)
	) else $error("PC moved while the core was halted");

	no_store_on_halt: assert property (
		@(posedge clk) !(st_valid_i && hlt_i)
	) else $error("Store strobe together with halt");

	no_store_in_reset: assert property (
		@(posedge clk) !rst_n_i |-> !st_valid_i
	) else $error("Store strobe during reset");

endmodule

bind cpu cpu_checker u_checker (
	.clk        (clk),
	.rst_n_i    (rst_n_i),
	.hlt_i      (hlt_o),
	.st_valid_i (st_valid_o),
	.pc_i       (pc_o)
);

`default_nettype wire

// ==== test/cpu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;

	localparam int NUM_ENTRIES = 5;
	localparam int PROG_LEN    = 16;
	localparam int MAX_STORES  = 8;
	localparam int CYCLE_LIMIT = 40 * NUM_ENTRIES;

	logic                       clk;
	logic                       rst_n_i;
	logic                       imem_we_i;
	logic [7:0]                 imem_addr_i;
	logic [cpu_pkg::DATA_W-1:0] imem_wdata_i;
	logic                       hlt_o;
	logic [cpu_pkg::DATA_W-1:0] pc_o;
	logic                       st_valid_o;
	logic [cpu_pkg::DATA_W-1:0] st_addr_o;
	logic [cpu_pkg::DATA_W-1:0] st_data_o;

	// Stimulus table with one program per entry
	logic [15:0] prog        [NUM_ENTRIES][PROG_LEN];
	int          prog_len    [NUM_ENTRIES];
	logic [15:0] st_addr_tab [NUM_ENTRIES][MAX_STORES];
	logic [15:0] st_data_tab [NUM_ENTRIES][MAX_STORES];
	int          st_count    [NUM_ENTRIES];
	logic [15:0] final_pc    [NUM_ENTRIES];
	int          cur_entry;
	int          cycle_count = 0;

	cpu uut (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.imem_we_i    (imem_we_i),
		.imem_addr_i  (imem_addr_i),
		.imem_wdata_i (imem_wdata_i),
		.hlt_o        (hlt_o),
		.pc_o         (pc_o),
		.st_valid_o   (st_valid_o),
		.st_addr_o    (st_addr_o),
		.st_data_o    (st_data_o)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the programs did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Testbench failed");
			$fatal(1, "Run stopped by cycle limit");
		end
	end

	// ************************************************************************
	// Instruction encoding
	// ************************************************************************

	function automatic logic [15:0] reg_form(cpu_pkg::opcode_e op, logic [3:0] a,
	                                         logic [3:0] b, logic [3:0] c);
		return {op, a, b, c};
	endfunction

	function automatic logic [15:0] byte_form(cpu_pkg::opcode_e op, logic [3:0] rd,
	                                          logic [7:0] val);
		return {op, rd, val};
	endfunction

	function automatic logic [15:0] branch_form(cpu_pkg::cond_e cond, logic [8:0] off);
		return {cpu_pkg::OP_B, cond, off};
	endfunction

	task automatic emit_instr(input logic [15:0] word);
		prog[cur_entry][prog_len[cur_entry]] = word;
		prog_len[cur_entry]++;
	endtask

	task automatic expect_store(input logic [15:0] addr, input logic [15:0] data);
		st_addr_tab[cur_entry][st_count[cur_entry]] = addr;
		st_data_tab[cur_entry][st_count[cur_entry]] = data;
		st_count[cur_entry]++;
	endtask

	task automatic check_value(input string name, input logic [15:0] actual,
	                           input logic [15:0] expected);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			$display("Testbench failed");
			$fatal(1, "Value mismatch");
		end
	endtask

	task automatic build_table();
		for (int e = 0; e < NUM_ENTRIES; e++) begin
			prog_len[e] = 0;
			st_count[e] = 0;
			for (int i = 0; i < PROG_LEN; i++) begin
				prog[e][i] = reg_form(cpu_pkg::OP_HLT, 4'd0, 4'd0, 4'd0);
			end
		end

		// Byte constants then ADD SUB XOR AND and a discarded write to r0
		cur_entry = 0;
		emit_instr(byte_form(cpu_pkg::OP_LLB, 4'd1, 8'h34));
		emit_instr(byte_form(cpu_pkg::OP_LHB, 4'd1, 8'h12));
		emit_instr(byte_form(cpu_pkg::OP_LLB, 4'd2, 8'h0F));
		emit_instr(byte_form(cpu_pkg::OP_LHB, 4'd2, 8'hF0));
		emit_instr(reg_form(cpu_pkg::OP_ADD, 4'd3, 4'd1, 4'd2));
		emit_instr(reg_form(cpu_pkg::OP_SW, 4'd3, 4'd0, 4'd0));
		emit_instr(reg_form(cpu_pkg::OP_SUB, 4'd4, 4'd1, 4'd2));
		emit_instr(reg_form(cpu_pkg::OP_SW, 4'd4, 4'd0, 4'd1));
		emit_instr(reg_form(cpu_pkg::OP_XOR, 4'd5, 4'd1, 4'd2));
		emit_instr(reg_form(cpu_pkg::OP_SW, 4'd5, 4'd0, 4'd2));
		emit_instr(reg_form(cpu_pkg::OP_AND, 4'd6, 4'd1, 4'd2));
		emit_instr(reg_form(cpu_pkg::OP_SW, 4'd6, 4'd0, 4'd3));
		emit_instr(reg_form(cpu_pkg::OP_ADD, 4'd0, 4'd1, 4'd2));
		emit_instr(reg_form(cpu_pkg::OP_SW, 4'd0, 4'd0, 4'd4));
		emit_instr(reg_form(cpu_pkg::OP_HLT, 4'd0, 4'd0, 4'd0));
		expect_store(16'h0000, 16'h0243);
		expect_store(16'h0001, 16'h2225);
		expect_store(16'h0002, 16'hE23B);
		expect_store(16'h0003, 16'h1004);
		expect_store(16'h0004, 16'h0000);
		final_pc[0] = 16'd14;

		// Shifts and OR on 0x9681
		cur_entry = 1;
		emit_instr(byte_form(cpu_pkg::OP_LLB, 4'd1, 8'h81));
		emit_instr(byte_form(cpu_pkg::OP_LHB, 4'd1, 8'h96));
		emit_instr(reg_form(cpu_pkg::OP_SLL, 4'd2, 4'd1, 4'd4));
		emit_instr(reg_form(cpu_pkg::OP_SW, 4'd2, 4'd0, 4'd0));
		emit_instr(reg_form(cpu_pkg::OP_SRA, 4'd3, 4'd1, 4'd4));
		emit_instr(reg_form(cpu_pkg::OP_SW, 4'd3, 4'd0, 4'd1));
		emit_instr(reg_form(cpu_pkg::OP_ROR, 4'd4, 4'd1, 4'd4));
		emit_instr(reg_form(cpu_pkg::OP_SW, 4'd4, 4'd0, 4'd2));
		emit_instr(reg_form(cpu_pkg::OP_OR, 4'd5, 4'd1, 4'd2));
		emit_instr(reg_form(cpu_pkg::OP_SW, 4'd5, 4'd0, 4'd3));
		emit_instr(reg_form(cpu_pkg::OP_HLT, 4'd0, 4'd0, 4'd0));
		expect_store(16'h0000, 16'h6810);
		expect_store(16'h0001, 16'hF968);
		expect_store(16'h0002, 16'h1968);
		expect_store(16'h0003, 16'hFE91);
		final_pc[1] = 16'd10;

		// Overflow and sign flags decide which marker stores happen
		cur_entry = 2;
		emit_instr(byte_form(cpu_pkg::OP_LLB, 4'd1, 8'hFF));
		emit_instr(byte_form(cpu_pkg::OP_LHB, 4'd1, 8'h7F));
		emit_instr(byte_form(cpu_pkg::OP_LLB, 4'd2, 8'h01));
		emit_instr(reg_form(cpu_pkg::OP_ADD, 4'd3, 4'd1, 4'd2));
		emit_instr(branch_form(cpu_pkg::COND_OV, 9'd1));
		emit_instr(reg_form(cpu_pkg::OP_SW, 4'd2, 4'd0, 4'd0));
		emit_instr(reg_form(cpu_pkg::OP_SW, 4'd3, 4'd0, 4'd1));
		emit_instr(reg_form(cpu_pkg::OP_SUB, 4'd4, 4'd2, 4'd1));
		emit_instr(branch_form(cpu_pkg::COND_LT, 9'd1));
		emit_instr(reg_form(cpu_pkg::OP_SW, 4'd2, 4'd0, 4'd2));
		emit_instr(branch_form(cpu_pkg::COND_GE, 9'd1));
		emit_instr(reg_form(cpu_pkg::OP_SW, 4'd4, 4'd0, 4'd3));
		emit_instr(branch_form(cpu_pkg::COND_OV, 9'd1));
		emit_instr(reg_form(cpu_pkg::OP_SW, 4'd1, 4'd0, 4'd4));
		emit_instr(reg_form(cpu_pkg::OP_HLT, 4'd0, 4'd0, 4'd0));
		expect_store(16'h0001, 16'h8000);
		expect_store(16'h0003, 16'h8002);
		expect_store(16'h0004, 16'h7FFF);
		final_pc[2] = 16'd14;

		// Store then load back from the same address and store again
		cur_entry = 3;
		emit_instr(byte_form(cpu_pkg::OP_LLB, 4'd1, 8'hCD));
		emit_instr(byte_form(cpu_pkg::OP_LHB, 4'd1, 8'hAB));
		emit_instr(byte_form(cpu_pkg::OP_LLB, 4'd2, 8'h10));
		emit_instr(reg_form(cpu_pkg::OP_SW, 4'd1, 4'd2, 4'hF));
		emit_instr(reg_form(cpu_pkg::OP_LW, 4'd3, 4'd2, 4'hF));
		emit_instr(reg_form(cpu_pkg::OP_SW, 4'd3, 4'd2, 4'd2));
		emit_instr(reg_form(cpu_pkg::OP_HLT, 4'd0, 4'd0, 4'd0));
		expect_store(16'h000F, 16'hABCD);
		expect_store(16'h0012, 16'hABCD);
		final_pc[3] = 16'd6;

		// PCS saves 3 and BR NE loops back once until r6 reaches zero
		cur_entry = 4;
		emit_instr(byte_form(cpu_pkg::OP_LLB, 4'd6, 8'h10));
		emit_instr(byte_form(cpu_pkg::OP_LLB, 4'd7, 8'h08));
		emit_instr(reg_form(cpu_pkg::OP_PCS, 4'd1, 4'd0, 4'd0));
		emit_instr(reg_form(cpu_pkg::OP_SW, 4'd6, 4'd0, 4'd0));
		emit_instr(reg_form(cpu_pkg::OP_SUB, 4'd6, 4'd6, 4'd7));
		emit_instr(reg_form(cpu_pkg::OP_BR, {cpu_pkg::COND_NE, 1'b0}, 4'd1, 4'd0));
		emit_instr(reg_form(cpu_pkg::OP_SW, 4'd1, 4'd0, 4'd1));
		emit_instr(reg_form(cpu_pkg::OP_HLT, 4'd0, 4'd0, 4'd0));
		expect_store(16'h0000, 16'h0010);
		expect_store(16'h0000, 16'h0008);
		expect_store(16'h0001, 16'h0003);
		final_pc[4] = 16'd7;
	endtask

	// ************************************************************************
	// Program load and run
	// ************************************************************************

	// Core stays in reset while the program is written
	task automatic load_program(input int e);
		for (int i = 0; i < PROG_LEN; i++) begin
			@(negedge clk);
			rst_n_i      = 1'b0;
			imem_we_i    = 1'b1;
			imem_addr_i  = 8'(i);
			imem_wdata_i = prog[e][i];
		end
		@(negedge clk);
		imem_we_i = 1'b0;
		rst_n_i   = 1'b1;
	endtask

	task automatic run_program(input int e);
		int   n_st;
		logic halted;

		n_st   = 0;
		halted = 1'b0;
		while (!halted) begin
			@(negedge clk);
			if (st_valid_o) begin
				if (n_st >= st_count[e]) begin
					check_value("store count", 16'(n_st + 1), 16'(st_count[e]));
				end
				check_value("st_addr_o", st_addr_o, st_addr_tab[e][n_st]);
				check_value("st_data_o", st_data_o, st_data_tab[e][n_st]);
				n_st++;
			end
			if (hlt_o) begin
				halted = 1'b1;
			end
		end
		check_value("pc_o", pc_o, final_pc[e]);
		check_value("store count", 16'(n_st), 16'(st_count[e]));

		// Halted core must stay frozen
		repeat (3) begin
			@(negedge clk);
			check_value("pc_o", pc_o, final_pc[e]);
			check_value("st_valid_o", {15'b0, st_valid_o}, 16'h0000);
		end
	endtask

	initial begin
		clk          = 1'b0;
		rst_n_i      = 1'b0;
		imem_we_i    = 1'b0;
		imem_addr_i  = '0;
		imem_wdata_i = '0;
		build_table();
		repeat (4) @(negedge clk);
		for (int e = 0; e < NUM_ENTRIES; e++) begin
			load_program(e);
			run_program(e);
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/cpu_pkg.sv
rtl/decode_if.sv
rtl/decoder.sv
rtl/pc_control.sv
rtl/register_file.sv
rtl/alu.sv
rtl/word_memory.sv
rtl/cpu.sv
test/cpu_checker.sv
test/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu

sources:
  - rtl/cpu_pkg.sv
  - rtl/decode_if.sv
  - rtl/decoder.sv
  - rtl/pc_control.sv
  - rtl/register_file.sv
  - rtl/alu.sv
  - rtl/word_memory.sv
  - rtl/cpu.sv
  - target: test
    files:
      - test/cpu_checker.sv
      - test/cpu_tb.sv
